// File: hdl/cnn_num_pkg.sv
package cnn_num_pkg;

	// Q8.8 fixed point for pixels, weights and biases
	localparam int word_w = 16;
	localparam int frac_w = 8;

	// headroom for a full vector of 32-bit products
	localparam int acc_w = 40;

	typedef logic signed [word_w-1:0] word_t;
	typedef logic signed [acc_w-1:0] acc_t;

endpackage

// File: hdl/fc_bias_chain.sv
`timescale 1ns/1ps

module fc_bias_chain #(
	parameter int N_OUT = 10,
	parameter int CNT_W = 16
) (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           load_en,
	input  cnn_num_pkg::word_t             bias_in,
	output cnn_num_pkg::word_t [N_OUT-1:0] bias_out
);
	import cnn_num_pkg::*;

	logic [CNT_W-1:0] fill_cnt;
	logic full;

	assign full = (fill_cnt == CNT_W'(N_OUT));

	// idle gaps between bursts rewind the fill count
	fc_counter #(
		.CNT_W(CNT_W)
	) fill_ctr_i (
		.clk(clk),
		.rst(rst),
		.clear(!load_en),
		.hold(full),
		.count(fill_cnt)
	);

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			bias_out <= '0;
		end
		else if (load_en && !full)
		begin
			for (int k = 0; k < N_OUT - 1; k++)
				bias_out[k] <= bias_out[k+1];
			bias_out[N_OUT-1] <= bias_in;
		end
	end

endmodule

// File: hdl/fc_buffers.sv
`timescale 1ns/1ps

module fc_buffers #(
	parameter int ROWS  = 4,
	parameter int COLS  = 4,
	parameter int N_OUT = 10,
	parameter int CNT_W = 16
) (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           wr_en,
	input  fc_ctrl_pkg::wr_target_t        wr_target,
	input  logic [CNT_W-1:0]               wr_addr,
	input  cnn_num_pkg::word_t [N_OUT-1:0] wr_data,
	input  logic [CNT_W-1:0]               read_row_addr,
	input  logic [CNT_W-1:0]               read_col_addr,
	input  logic                           read_pixel_en,
	input  logic [CNT_W-1:0]               read_weight_addr,
	input  logic                           read_weight_en,
	input  logic [CNT_W-1:0]               read_bias_addr,
	input  logic                           read_bias_en,
	output cnn_num_pkg::word_t             pixel_data,
	output cnn_num_pkg::word_t [N_OUT-1:0] weight_data,
	output cnn_num_pkg::word_t             bias_data
);
	import cnn_num_pkg::*;
	import fc_ctrl_pkg::*;

	localparam int N_IN = ROWS * COLS;
	localparam int PIX_AW = (N_IN > 1) ? $clog2(N_IN) : 1;
	localparam int BIAS_AW = (N_OUT > 1) ? $clog2(N_OUT) : 1;

	word_t pixel_mem [N_IN];
	word_t [N_OUT-1:0] weight_mem [N_IN];
	word_t bias_mem [N_OUT];
	logic [CNT_W-1:0] pix_rd_addr;

	// row-major pixel layout
	assign pix_rd_addr = read_row_addr * CNT_W'(COLS) + read_col_addr;

	always_ff @(posedge clk)
	begin
		if (wr_en)
		begin
			case (wr_target)
				WR_PIXEL:  pixel_mem[wr_addr[PIX_AW-1:0]] <= wr_data[0];
				WR_WEIGHT: weight_mem[wr_addr[PIX_AW-1:0]] <= wr_data;
				WR_BIAS:   bias_mem[wr_addr[BIAS_AW-1:0]] <= wr_data[0];
				default:   ;
			endcase
		end
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			pixel_data <= '0;
			weight_data <= '0;
			bias_data <= '0;
		end
		else
		begin
			if (read_pixel_en)
				pixel_data <= pixel_mem[pix_rd_addr[PIX_AW-1:0]];
			if (read_weight_en)
				weight_data <= weight_mem[read_weight_addr[PIX_AW-1:0]];
			if (read_bias_en)
				bias_data <= bias_mem[read_bias_addr[BIAS_AW-1:0]];
		end
	end

endmodule

// File: hdl/fc_counter.sv
`timescale 1ns/1ps

module fc_counter #(
	parameter int CNT_W = 16
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             clear,
	input  logic             hold,
	output logic [CNT_W-1:0] count
);
	import cnn_num_pkg::*;

	// clear wins over hold
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			count <= '0;
		end
		else if (clear)
		begin
			count <= '0;
		end
		else if (!hold)
		begin
			count <= count + CNT_W'(1);
		end
	end

endmodule

// File: hdl/fc_ctrl_pkg.sv
package fc_ctrl_pkg;

	// pixel and weight read sequencer
	typedef enum logic [1:0] {
		READ_IDLE,
		READ_SETUP,
		READ_RUN
	} read_state_t;

	// bias read loader
	typedef enum logic {
		BIAS_IDLE,
		BIAS_LOAD
	} bias_state_t;

	// which buffer the external write port targets
	typedef enum logic [1:0] {
		WR_PIXEL,
		WR_WEIGHT,
		WR_BIAS
	} wr_target_t;

endpackage

// File: hdl/fc_layer.sv
`timescale 1ns/1ps

module fc_layer #(
	parameter int ROWS  = 4,
	parameter int COLS  = 4,
	parameter int N_OUT = 10,
	parameter int CNT_W = 16
) (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           bias_store_done,
	input  logic                           pixel_store_done,
	input  cnn_num_pkg::word_t             pixel_data,
	input  cnn_num_pkg::word_t [N_OUT-1:0] weight_data,
	input  cnn_num_pkg::word_t             bias_data,
	output logic [CNT_W-1:0]               read_row_addr,
	output logic [CNT_W-1:0]               read_col_addr,
	output logic                           read_pixel_en,
	output logic [CNT_W-1:0]               read_weight_addr,
	output logic                           read_weight_en,
	output logic [CNT_W-1:0]               read_bias_addr,
	output logic                           read_bias_en,
	output logic                           busy,
	output logic                           layer_done,
	output cnn_num_pkg::word_t [N_OUT-1:0] output_data
);
	import cnn_num_pkg::*;
	import fc_ctrl_pkg::*;

	localparam int N_IN = ROWS * COLS;

	read_state_t read_state;
	read_state_t read_next;
	bias_state_t bias_state;
	bias_state_t bias_next;

	logic start;
	logic run;
	logic col_wrap;
	logic pix_last;
	logic bias_last;

	// [0] lines up with memory output, [1] with the local data registers
	logic [1:0] beat_sr;
	logic [1:0] first_sr;
	logic [1:0] last_sr;
	logic [1:0] bias_sr;
	logic done_d;

	word_t pix_q;
	word_t [N_OUT-1:0] wgt_q;
	word_t bias_q;
	word_t [N_OUT-1:0] bias_slots;

	// late start pulses are dropped while busy
	assign start = pixel_store_done && !busy;
	assign run = (read_state == READ_RUN);
	assign col_wrap = (read_col_addr == CNT_W'(COLS - 1));
	assign pix_last = (read_weight_addr == CNT_W'(N_IN - 1));
	assign bias_last = (read_bias_addr == CNT_W'(N_OUT - 1));

	assign read_pixel_en = run;
	assign read_weight_en = run;
	assign read_bias_en = (bias_state == BIAS_LOAD);

	always_comb
	begin
		read_next = read_state;
		case (read_state)
			READ_IDLE:  if (start) read_next = READ_SETUP;
			READ_SETUP: read_next = READ_RUN;
			READ_RUN:   if (pix_last) read_next = READ_IDLE;
			default:    read_next = READ_IDLE;
		endcase
	end

	always_comb
	begin
		bias_next = bias_state;
		case (bias_state)
			BIAS_IDLE: if (bias_store_done) bias_next = BIAS_LOAD;
			BIAS_LOAD: if (bias_last) bias_next = BIAS_IDLE;
			default:   bias_next = BIAS_IDLE;
		endcase
	end

	fc_counter #(.CNT_W(CNT_W)) row_ctr_i (
		.clk(clk),
		.rst(rst),
		.clear(!run),
		.hold(!col_wrap),
		.count(read_row_addr)
	);

	fc_counter #(.CNT_W(CNT_W)) col_ctr_i (
		.clk(clk),
		.rst(rst),
		.clear(!run || col_wrap),
		.hold(1'b0),
		.count(read_col_addr)
	);

	// weight row index runs in step with the pixel index
	fc_counter #(.CNT_W(CNT_W)) wgt_ctr_i (
		.clk(clk),
		.rst(rst),
		.clear(!run),
		.hold(1'b0),
		.count(read_weight_addr)
	);

	fc_counter #(.CNT_W(CNT_W)) bias_ctr_i (
		.clk(clk),
		.rst(rst),
		.clear(!read_bias_en),
		.hold(1'b0),
		.count(read_bias_addr)
	);

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			read_state <= READ_IDLE;
			bias_state <= BIAS_IDLE;
			beat_sr <= '0;
			first_sr <= '0;
			last_sr <= '0;
			bias_sr <= '0;
			done_d <= 1'b0;
			layer_done <= 1'b0;
			busy <= 1'b0;
		end
		else
		begin
			read_state <= read_next;
			bias_state <= bias_next;
			beat_sr <= {beat_sr[0], run};
			first_sr <= {first_sr[0], run && (read_weight_addr == '0)};
			last_sr <= {last_sr[0], run && pix_last};
			bias_sr <= {bias_sr[0], read_bias_en};
			// lanes need one edge after the last beat to register results
			done_d <= last_sr[1];
			layer_done <= done_d;
			if (start)
				busy <= 1'b1;
			else if (done_d)
				busy <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (beat_sr[0])
		begin
			pix_q <= pixel_data;
			wgt_q <= weight_data;
		end
		if (bias_sr[0])
			bias_q <= bias_data;
	end

	fc_bias_chain #(
		.N_OUT(N_OUT),
		.CNT_W(CNT_W)
	) bias_chain_i (
		.clk(clk),
		.rst(rst),
		.load_en(bias_sr[1]),
		.bias_in(bias_q),
		.bias_out(bias_slots)
	);

	for (genvar k = 0; k < N_OUT; k++)
	begin : g_lane
		fc_mac_lane lane_i (
			.clk(clk),
			.rst(rst),
			.pixel(pix_q),
			.weight(wgt_q[k]),
			.bias(bias_slots[k]),
			.acc_en(beat_sr[1]),
			.first_beat(first_sr[1]),
			.result(output_data[k])
		);
	end

	done_pulse: assert property (@(posedge clk) disable iff (rst) layer_done |=> !layer_done)
		else $error("layer_done wider than one cycle");

	// idle must pass through setup before any read
	idle_no_read: assert property (@(posedge clk) disable iff (rst)
		(read_state == READ_IDLE) |=> !(read_pixel_en || read_weight_en))
		else $error("pixel or weight read issued straight out of idle");

endmodule

// File: hdl/fc_mac_lane.sv
`timescale 1ns/1ps

module fc_mac_lane (
	input  logic               clk,
	input  logic               rst,
	input  cnn_num_pkg::word_t pixel,
	input  cnn_num_pkg::word_t weight,
	input  cnn_num_pkg::word_t bias,
	input  logic               acc_en,
	input  logic               first_beat,
	output cnn_num_pkg::word_t result
);
	import cnn_num_pkg::*;

	logic signed [2*word_w-1:0] product;
	acc_t acc;
	acc_t biased;
	logic acc_en_q;

	assign product = pixel * weight;

	// bias moved up to the binary point of the products
	assign biased = acc + (acc_t'(bias) <<< frac_w);

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			acc <= '0;
			acc_en_q <= 1'b0;
			result <= '0;
		end
		else
		begin
			acc_en_q <= acc_en;
			if (acc_en)
			begin
				if (first_beat)
					acc <= acc_t'(product);
				else
					acc <= acc + acc_t'(product);
			end
			// last beat just landed, result held until the next run ends
			if (acc_en_q && !acc_en)
				result <= word_t'(biased >>> frac_w);
		end
	end

	first_in_beat: assert property (@(posedge clk) disable iff (rst) first_beat |-> acc_en)
		else $error("first_beat seen outside an accumulate beat");

endmodule

// File: hdl/fc_top.sv
`timescale 1ns/1ps

module fc_top #(
	parameter int ROWS  = 4,
	parameter int COLS  = 4,
	parameter int N_OUT = 10,
	parameter int CNT_W = 16
) (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           wr_en,
	input  fc_ctrl_pkg::wr_target_t        wr_target,
	input  logic [CNT_W-1:0]               wr_addr,
	input  cnn_num_pkg::word_t [N_OUT-1:0] wr_data,
	input  logic                           bias_store_done,
	input  logic                           pixel_store_done,
	output logic                           busy,
	output logic                           layer_done,
	output cnn_num_pkg::word_t [N_OUT-1:0] output_data
);
	import cnn_num_pkg::*;

	logic [CNT_W-1:0] read_row_addr;
	logic [CNT_W-1:0] read_col_addr;
	logic read_pixel_en;
	logic [CNT_W-1:0] read_weight_addr;
	logic read_weight_en;
	logic [CNT_W-1:0] read_bias_addr;
	logic read_bias_en;
	word_t pixel_data;
	word_t [N_OUT-1:0] weight_data;
	word_t bias_data;

	fc_buffers #(
		.ROWS(ROWS),
		.COLS(COLS),
		.N_OUT(N_OUT),
		.CNT_W(CNT_W)
	) buffers_i (
		.clk(clk),
		.rst(rst),
		.wr_en(wr_en),
		.wr_target(wr_target),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.read_row_addr(read_row_addr),
		.read_col_addr(read_col_addr),
		.read_pixel_en(read_pixel_en),
		.read_weight_addr(read_weight_addr),
		.read_weight_en(read_weight_en),
		.read_bias_addr(read_bias_addr),
		.read_bias_en(read_bias_en),
		.pixel_data(pixel_data),
		.weight_data(weight_data),
		.bias_data(bias_data)
	);

	fc_layer #(
		.ROWS(ROWS),
		.COLS(COLS),
		.N_OUT(N_OUT),
		.CNT_W(CNT_W)
	) layer_i (
		.clk(clk),
		.rst(rst),
		.bias_store_done(bias_store_done),
		.pixel_store_done(pixel_store_done),
		.pixel_data(pixel_data),
		.weight_data(weight_data),
		.bias_data(bias_data),
		.read_row_addr(read_row_addr),
		.read_col_addr(read_col_addr),
		.read_pixel_en(read_pixel_en),
		.read_weight_addr(read_weight_addr),
		.read_weight_en(read_weight_en),
		.read_bias_addr(read_bias_addr),
		.read_bias_en(read_bias_en),
		.busy(busy),
		.layer_done(layer_done),
		.output_data(output_data)
	);

endmodule

// File: project.f
hdl/cnn_num_pkg.sv
hdl/fc_ctrl_pkg.sv
hdl/fc_counter.sv
hdl/fc_mac_lane.sv
hdl/fc_bias_chain.sv
hdl/fc_buffers.sv
hdl/fc_layer.sv
hdl/fc_top.sv
tb/fc_tb.sv

// File: run.sh
#!/bin/sh
# build with Verilator and run, pass is decided from the simulation output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module fc_tb -o fc_sim \
	&& ./obj_dir/fc_sim | tee /dev/stderr | grep -q "TEST OK" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// File: tb/fc_tb.sv
`timescale 1ns/1ps

module fc_tb;
	import cnn_num_pkg::*;
	import fc_ctrl_pkg::*;

	localparam int ROWS = 4;
	localparam int COLS = 4;
	localparam int N_OUT = 10;
	localparam int CNT_W = 16;
	localparam int N_IN = ROWS * COLS;
	localparam int runs = 5;
	localparam int loads = 7;
	localparam int watchdog_cycles = runs * (N_IN + 10) + loads * 200;

	logic clk;
	logic rst;
	logic wr_en;
	wr_target_t wr_target;
	logic [CNT_W-1:0] wr_addr;
	word_t [N_OUT-1:0] wr_data;
	logic bias_store_done;
	logic pixel_store_done;
	logic busy;
	logic layer_done;
	word_t [N_OUT-1:0] output_data;
	logic start_exp;

	integer seed;
	word_t pix_ref [N_IN];
	word_t wgt_ref [N_IN][N_OUT];
	word_t bias_ref [N_OUT];
	word_t exp_out [N_OUT];

	fc_top #(
		.ROWS(ROWS),
		.COLS(COLS),
		.N_OUT(N_OUT),
		.CNT_W(CNT_W)
	) fc_top_i (
		.clk(clk),
		.rst(rst),
		.wr_en(wr_en),
		.wr_target(wr_target),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.bias_store_done(bias_store_done),
		.pixel_store_done(pixel_store_done),
		.busy(busy),
		.layer_done(layer_done),
		.output_data(output_data)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic fail_run(string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic report_mismatch(string sig, int expected, int actual);
		$display("MISMATCH time=%0t signal=%s expected=%0d actual=%0d",
			$time, sig, expected, actual);
		fail_run("output value differs from the reference");
	endtask

	// small range keeps sums clear of wrap
	function automatic word_t rand_word();
		return word_t'($random(seed) % 512);
	endfunction

	function automatic word_t lane_ref(int k);
		longint sum;
		sum = longint'(bias_ref[k]) <<< frac_w;
		for (int i = 0; i < N_IN; i++)
			sum += longint'(pix_ref[i]) * longint'(wgt_ref[i][k]);
		return word_t'(sum >>> frac_w);
	endfunction

	task automatic update_expected();
		for (int k = 0; k < N_OUT; k++)
			exp_out[k] = lane_ref(k);
	endtask

	task automatic write_word(wr_target_t tgt, int addr, word_t [N_OUT-1:0] data);
		@(posedge clk);
		#2;
		wr_en = 1'b1;
		wr_target = tgt;
		wr_addr = CNT_W'(addr);
		wr_data = data;
		@(posedge clk);
		#2;
		wr_en = 1'b0;
	endtask

	task automatic load_bias();
		word_t [N_OUT-1:0] data;
		data = '0;
		for (int k = 0; k < N_OUT; k++)
		begin
			bias_ref[k] = rand_word();
			data[0] = bias_ref[k];
			write_word(WR_BIAS, k, data);
		end
		@(posedge clk);
		#2;
		bias_store_done = 1'b1;
		@(posedge clk);
		#2;
		bias_store_done = 1'b0;
		// chain fill time is fixed by the loader
		repeat (N_OUT + 4) @(posedge clk);
	endtask

	task automatic load_weights();
		word_t [N_OUT-1:0] row;
		for (int i = 0; i < N_IN; i++)
		begin
			for (int k = 0; k < N_OUT; k++)
			begin
				row[k] = rand_word();
				wgt_ref[i][k] = row[k];
			end
			write_word(WR_WEIGHT, i, row);
		end
	endtask

	task automatic load_pixels(bit zero);
		word_t [N_OUT-1:0] data;
		data = '0;
		for (int r = 0; r < ROWS; r++)
		begin
			for (int c = 0; c < COLS; c++)
			begin
				pix_ref[r * COLS + c] = zero ? word_t'(0) : rand_word();
				data[0] = pix_ref[r * COLS + c];
				write_word(WR_PIXEL, r * COLS + c, data);
			end
		end
	endtask

	// start_exp marks the starts the DUT has to accept
	task automatic start_run();
		@(posedge clk);
		#2;
		pixel_store_done = 1'b1;
		start_exp = 1'b1;
		@(posedge clk);
		#2;
		pixel_store_done = 1'b0;
		start_exp = 1'b0;
	endtask

	task automatic wait_done();
		int n;
		n = 0;
		@(negedge clk);
		while (!layer_done)
		begin
			n++;
			if (n > N_IN + 10)
				fail_run("layer_done did not arrive after the run started");
			@(negedge clk);
		end
		// let the lane checks sample the result
		@(posedge clk);
	endtask

	task automatic check_reset_state();
		assert (layer_done == 1'b0)
			else report_mismatch("layer_done", 0, int'(layer_done));
		assert (busy == 1'b0)
			else report_mismatch("busy", 0, int'(busy));
		for (int k = 0; k < N_OUT; k++)
			assert (output_data[k] == '0)
				else report_mismatch($sformatf("output_data[%0d]", k), 0,
					int'(output_data[k]));
	endtask

	for (genvar k = 0; k < N_OUT; k++)
	begin : g_lane_check
		lane_value: assert property (@(posedge clk) disable iff (rst)
			layer_done |-> output_data[k] == exp_out[k])
			else report_mismatch($sformatf("output_data[%0d]", k), int'(exp_out[k]),
				int'(output_data[k]));
	end

	done_width: assert property (@(posedge clk) disable iff (rst) layer_done |=> !layer_done)
		else fail_run("layer_done stayed high for more than one cycle");

	done_timing: assert property (@(posedge clk) disable iff (rst)
		$rose(layer_done) |-> $past(start_exp, N_IN + 5))
		else fail_run("layer_done rose at the wrong distance from the accepted start");

	busy_on_start: assert property (@(posedge clk) disable iff (rst) start_exp |=> busy)
		else fail_run("busy did not rise after the run started");

	busy_off_at_done: assert property (@(posedge clk) disable iff (rst) layer_done |-> !busy)
		else fail_run("busy still high when layer_done rose");

	initial
	begin
		repeat (watchdog_cycles) @(posedge clk);
		fail_run("watchdog expired before the tests finished");
	end

	initial
	begin
		seed = 32'hfbfd272a;
		rst = 1'b1;
		wr_en = 1'b0;
		wr_target = WR_PIXEL;
		wr_addr = '0;
		wr_data = '0;
		bias_store_done = 1'b0;
		pixel_store_done = 1'b0;
		start_exp = 1'b0;
		repeat (8) @(posedge clk);
		#2;
		rst = 1'b0;
		@(negedge clk);
		check_reset_state();

		load_bias();
		load_weights();
		load_pixels(1'b0);
		update_expected();
		start_run();
		wait_done();

		// accumulators must clear between runs
		load_pixels(1'b0);
		update_expected();
		start_run();
		wait_done();

		// zero vector leaves only the bias
		load_pixels(1'b1);
		update_expected();
		start_run();
		wait_done();

		load_bias();
		update_expected();
		start_run();
		wait_done();

		// extra start in the middle of a run is dropped
		load_pixels(1'b0);
		update_expected();
		start_run();
		repeat (5) @(posedge clk);
		#2;
		pixel_store_done = 1'b1;
		@(posedge clk);
		#2;
		pixel_store_done = 1'b0;
		wait_done();
		// a restarted run would raise layer_done again in this window
		repeat (N_IN + 10) @(posedge clk);

		$display("TEST OK");
		$finish;
	end

endmodule
